// ==== rtl/i2c_cfg.svh ====
// bus timing and byte width macros for the I2C master
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// i2c_clock cycles per quarter of an SCL bit
// one bit period is four times this value
`define I2C_PHASE_DIVIDE 1

// bits per byte field and per shift count
`define I2C_BYTE_BITS 8

`endif

// ==== rtl/i2cPkg.sv ====
// command, response, SCL phase and SDA line request types
`include "i2c_cfg.svh"

package i2cPkg;

	// one requested register access
	typedef struct packed {
		logic [6:0]                  deviceAddr;
		logic [`I2C_BYTE_BITS-1:0]   regAddr;
		logic [`I2C_BYTE_BITS-1:0]   writeData;
		logic                        isRead;
	} i2cCommand_t;

	// result of one access
	// readData stays zero after a write or a missing acknowledge
	typedef struct packed {
		logic [`I2C_BYTE_BITS-1:0]   readData;
		logic                        ackError;
	} i2cResponse_t;

	// quarter of the bit period, SCL high in rise and high
	typedef enum logic [1:0] {
		phaseLowEarly = 2'd0,
		phaseRise     = 2'd1,
		phaseHigh     = 2'd2,
		phaseLowLate  = 2'd3
	} sclPhase_t;

	// what SDA does over the current bit
	typedef enum logic [2:0] {
		actionIdle    = 3'd0,
		actionStart   = 3'd1,
		actionStop    = 3'd2,
		actionSendBit = 3'd3,
		actionRelease = 3'd4
	} sdaAction_t;

	// per-bit request from the sequencer to the line driver
	typedef struct packed {
		sdaAction_t  action;
		logic        bitValue;
	} lineRequest_t;

endpackage

// ==== rtl/sclPhaseGen.sv ====
// quarter-phase divider producing SCL, the current phase and the bit-end strobe
`timescale 1ns/1ns
`include "i2c_cfg.svh"

module sclPhaseGen (
	input  logic              i2c_clock,
	input  logic              reset,
	input  logic              running,
	output i2cPkg::sclPhase_t phase,
	output logic              bitEnd,
	output logic              scl
);

	localparam int divBits = (`I2C_PHASE_DIVIDE > 1) ? $clog2(`I2C_PHASE_DIVIDE) : 1;

	logic [divBits-1:0] divCount;
	logic               quarterEnd;
	logic               sclReg;

	assign quarterEnd = (divCount == divBits'(`I2C_PHASE_DIVIDE - 1));

	// counter parks at the start of a bit while the bus is idle
	always_ff @(posedge i2c_clock) begin
		if (reset || !running) begin
			divCount <= '0;
			phase    <= i2cPkg::phaseLowEarly;
		end else if (quarterEnd) begin
			divCount <= '0;
			phase    <= i2cPkg::sclPhase_t'(phase + 2'd1);
		end else begin
			divCount <= divCount + 1'b1;
		end
	end

	// registered so SCL lines up with the registered SDA pull-down
	always_ff @(posedge i2c_clock) begin
		if (reset) begin
			sclReg <= 1'b1;
		end else begin
			sclReg <= !running || (phase == i2cPkg::phaseRise) || (phase == i2cPkg::phaseHigh);
		end
	end

	// idle bus holds SCL high from the first cycle after stop
	assign scl = sclReg || !running;

	// last cycle of the late low quarter
	assign bitEnd = running && (phase == i2cPkg::phaseLowLate) && quarterEnd;

endmodule

// ==== rtl/transactionSequencer.sv ====
// transaction FSM with byte shift register, bit counter and command/response handshakes
`timescale 1ns/1ns
`include "i2c_cfg.svh"

module transactionSequencer (
	input  logic                 i2c_clock,
	input  logic                 reset,
	input  logic                 cmdValid,
	output logic                 cmdReady,
	input  i2cPkg::i2cCommand_t  cmdData,
	output logic                 rspValid,
	input  logic                 rspReady,
	output i2cPkg::i2cResponse_t rspData,
	input  logic                 bitEnd,
	input  logic                 sampledBit,
	output logic                 running,
	output i2cPkg::lineRequest_t lineReq
);

	localparam int countBits = $clog2(`I2C_BYTE_BITS);

	typedef enum logic [3:0] {
		stIdle,
		stStart,
		stDevice,
		stAck,
		stRegister,
		stData,
		stRestart,
		stReadAddr,
		stReadData,
		stMasterNack,
		stStop,
		stRespond
	} seqState_t;

	seqState_t                 state;
	// stage that follows a good acknowledge
	seqState_t                 ackNext;
	logic [countBits-1:0]      bitCount;
	logic                      lastBit;
	i2cPkg::i2cCommand_t       cmdReg;
	logic [`I2C_BYTE_BITS-1:0] shiftReg;
	i2cPkg::i2cResponse_t      rspReg;
	logic                      acceptCmd;
	logic                      rspTaken;

	assign lastBit   = (bitCount == countBits'(`I2C_BYTE_BITS - 1));
	assign acceptCmd = (state == stIdle) && cmdValid;
	assign rspTaken  = (state == stRespond) && rspReady;

	assign cmdReady = (state == stIdle);
	assign rspValid = (state == stRespond);
	assign rspData  = rspReg;
	assign running  = (state != stIdle) && (state != stRespond);

	// stage control, moves on bitEnd apart from the two handshakes
	always_ff @(posedge i2c_clock) begin
		if (reset) begin
			state    <= stIdle;
			ackNext  <= stIdle;
			bitCount <= '0;
		end else if (acceptCmd) begin
			state    <= stStart;
			bitCount <= '0;
		end else if (rspTaken) begin
			state <= stIdle;
		end else if (bitEnd) begin
			case (state)
				stStart: begin
					state   <= stDevice;
					ackNext <= stRegister;
				end
				stDevice, stRegister, stData, stReadAddr: begin
					if (lastBit) begin
						state    <= stAck;
						bitCount <= '0;
					end else begin
						bitCount <= bitCount + 1'b1;
					end
				end
				stAck: begin
					// NACK from the target aborts straight to stop
					if (sampledBit) begin
						state <= stStop;
					end else begin
						state <= ackNext;
						case (ackNext)
							stRegister: ackNext <= cmdReg.isRead ? stRestart : stData;
							stData:     ackNext <= stStop;
							default:    ackNext <= ackNext;
						endcase
					end
				end
				stRestart: begin
					state   <= stReadAddr;
					ackNext <= stReadData;
				end
				stReadData: begin
					if (lastBit) begin
						state    <= stMasterNack;
						bitCount <= '0;
					end else begin
						bitCount <= bitCount + 1'b1;
					end
				end
				stMasterNack: state <= stStop;
				stStop:       state <= stRespond;
				default:      state <= state;
			endcase
		end
	end

	// command copy, outgoing byte and response accumulation
	always_ff @(posedge i2c_clock) begin
		if (acceptCmd) begin
			cmdReg <= cmdData;
			rspReg <= '0;
		end else if (bitEnd) begin
			case (state)
				// first byte carries the direction in its low bit
				stStart:   shiftReg <= {cmdReg.deviceAddr, 1'b0};
				stRestart: shiftReg <= {cmdReg.deviceAddr, 1'b1};
				stDevice, stRegister, stData, stReadAddr: begin
					shiftReg <= shiftReg << 1;
				end
				stAck: begin
					if (sampledBit) begin
						rspReg.ackError <= 1'b1;
					end else if (ackNext == stRegister) begin
						shiftReg <= cmdReg.regAddr;
					end else if (ackNext == stData) begin
						shiftReg <= cmdReg.writeData;
					end
				end
				// MSB arrives first
				stReadData: begin
					rspReg.readData <= {rspReg.readData[`I2C_BYTE_BITS-2:0], sampledBit};
				end
				default: begin
					shiftReg <= shiftReg;
				end
			endcase
		end
	end

	// line request follows the stage, so it only moves on bitEnd while running
	always_comb begin
		lineReq.action   = i2cPkg::actionIdle;
		lineReq.bitValue = 1'b1;
		case (state)
			stStart, stRestart: begin
				lineReq.action = i2cPkg::actionStart;
			end
			stDevice, stRegister, stData, stReadAddr: begin
				lineReq.action   = i2cPkg::actionSendBit;
				lineReq.bitValue = shiftReg[`I2C_BYTE_BITS-1];
			end
			stAck, stReadData: begin
				lineReq.action = i2cPkg::actionRelease;
			end
			// single byte read ends with NACK, SDA left high
			stMasterNack: begin
				lineReq.action   = i2cPkg::actionSendBit;
				lineReq.bitValue = 1'b1;
			end
			stStop: begin
				lineReq.action = i2cPkg::actionStop;
			end
			default: begin
				lineReq.action = i2cPkg::actionIdle;
			end
		endcase
	end

endmodule

// ==== rtl/sdaLineDriver.sv ====
// SDA pull-down pattern per action and phase, plus the sampled SDA bit
`timescale 1ns/1ns

module sdaLineDriver (
	input  logic                 i2c_clock,
	input  logic                 reset,
	input  i2cPkg::sclPhase_t    phase,
	input  i2cPkg::lineRequest_t lineReq,
	input  logic                 sdaIn,
	output logic                 sdaPullLow,
	output logic                 sampledBit
);

	logic pullNext;

	always_comb begin
		case (lineReq.action)
			// high for the first half, falls while SCL is high
			i2cPkg::actionStart: begin
				pullNext = (phase == i2cPkg::phaseHigh) || (phase == i2cPkg::phaseLowLate);
			end
			// low for the first half, rises while SCL is high
			i2cPkg::actionStop: begin
				pullNext = (phase == i2cPkg::phaseLowEarly) || (phase == i2cPkg::phaseRise);
			end
			i2cPkg::actionSendBit: begin
				pullNext = !lineReq.bitValue;
			end
			default: begin
				pullNext = 1'b0;
			end
		endcase
	end

	// pull-down lags phase by one cycle, matching the registered SCL
	always_ff @(posedge i2c_clock) begin
		if (reset) begin
			sdaPullLow <= 1'b0;
			sampledBit <= 1'b1;
		end else begin
			sdaPullLow <= pullNext;
			if (phase == i2cPkg::phaseHigh) begin
				sampledBit <= sdaIn;
			end
		end
	end

endmodule

// ==== rtl/i2cMaster.sv ====
// I2C master top level wiring the phase generator, sequencer, line driver and pins
`timescale 1ns/1ns

module i2cMaster (
	input  logic                 i2c_clock,
	input  logic                 reset,
	input  logic                 cmdValid,
	output logic                 cmdReady,
	input  i2cPkg::i2cCommand_t  cmdData,
	output logic                 rspValid,
	input  logic                 rspReady,
	output i2cPkg::i2cResponse_t rspData,
	output logic                 sclPin,
	inout  wire                  sdaPin
);

	logic                 running;
	logic                 bitEnd;
	logic                 sampledBit;
	logic                 sdaPullLow;
	i2cPkg::sclPhase_t    phase;
	i2cPkg::lineRequest_t lineReq;

	sclPhaseGen i_sclPhaseGen (
		.i2c_clock (i2c_clock),
		.reset     (reset),
		.running   (running),
		.phase     (phase),
		.bitEnd    (bitEnd),
		.scl       (sclPin)
	);

	transactionSequencer i_transactionSequencer (
		.i2c_clock  (i2c_clock),
		.reset      (reset),
		.cmdValid   (cmdValid),
		.cmdReady   (cmdReady),
		.cmdData    (cmdData),
		.rspValid   (rspValid),
		.rspReady   (rspReady),
		.rspData    (rspData),
		.bitEnd     (bitEnd),
		.sampledBit (sampledBit),
		.running    (running),
		.lineReq    (lineReq)
	);

	sdaLineDriver i_sdaLineDriver (
		.i2c_clock  (i2c_clock),
		.reset      (reset),
		.phase      (phase),
		.lineReq    (lineReq),
		.sdaIn      (sdaPin),
		.sdaPullLow (sdaPullLow),
		.sampledBit (sampledBit)
	);

	// open drain, the pull-up sits outside the chip
	assign sdaPin = sdaPullLow ? 1'b0 : 1'bz;

endmodule

// ==== verification/i2cMaster_asserts.sv ====
// concurrent assertions on the command/response handshakes and the I2C bus lines
`timescale 1ns/1ns

module i2cMaster_asserts (
	input logic                 i2c_clock,
	input logic                 reset,
	input logic                 cmdValid,
	input logic                 cmdReady,
	input i2cPkg::i2cCommand_t  cmdData,
	input logic                 rspValid,
	input logic                 rspReady,
	input i2cPkg::i2cResponse_t rspData,
	input logic                 sclPin,
	input logic                 sdaPin,
	input i2cPkg::lineRequest_t lineReq
);

	int   assertFailures = 0;
	logic busEdgeAllowed;

	// only start and stop may move SDA while SCL is high
	assign busEdgeAllowed = (lineReq.action == i2cPkg::actionStart)
		|| (lineReq.action == i2cPkg::actionStop);

	cmdStable: assert property (@(posedge i2c_clock) disable iff (reset)
		cmdValid && !cmdReady |=> $stable(cmdData))
		else begin
			assertFailures++;
			$error("cmdData changed while waiting for cmdReady");
		end

	rspHeld: assert property (@(posedge i2c_clock) disable iff (reset)
		rspValid && !rspReady |=> rspValid && $stable(rspData))
		else begin
			assertFailures++;
			$error("response dropped or changed before rspReady");
		end

	sdaWhileSclHigh: assert property (@(posedge i2c_clock) disable iff (reset)
		sclPin && $past(sclPin) && $changed(sdaPin) |-> busEdgeAllowed)
		else begin
			assertFailures++;
			$error("SDA moved with SCL high outside start or stop");
		end

	// a new command is taken only once the previous response has gone out
	readyAfterResponse: assert property (@(posedge i2c_clock) disable iff (reset)
		$rose(cmdReady) |-> $past(rspValid && rspReady))
		else begin
			assertFailures++;
			$error("cmdReady returned before the response was taken");
		end

endmodule

bind i2cMaster i2cMaster_asserts i_i2cMaster_asserts (
	.i2c_clock (i2c_clock),
	.reset     (reset),
	.cmdValid  (cmdValid),
	.cmdReady  (cmdReady),
	.cmdData   (cmdData),
	.rspValid  (rspValid),
	.rspReady  (rspReady),
	.rspData   (rspData),
	.sclPin    (sclPin),
	.sdaPin    (sdaPin),
	.lineReq   (lineReq)
);

// ==== verification/i2cMaster_tb.sv ====
// testbench for the I2C master: clock, reset, target model, reference, stimulus, checker, watchdog
`timescale 1ns/1ns
`include "i2c_cfg.svh"

module i2cMaster_tb;

	localparam int         clkPeriod      = 20;
	localparam int         numCommands    = 48;
	localparam int         watchdogCycles = numCommands * 200 * `I2C_PHASE_DIVIDE;
	localparam logic [6:0] targetAddr     = 7'h2A;

	typedef enum {
		tIdle, tAddr, tReg, tWrData, tAckDrive, tAckHold, tRdData, tRdRelease, tRdNack
	} targetState_t;

	logic                 i2c_clock;
	logic                 reset;
	logic                 cmdValid;
	logic                 cmdReady;
	i2cPkg::i2cCommand_t  cmdData;
	logic                 rspValid;
	logic                 rspReady;
	i2cPkg::i2cResponse_t rspData;
	logic                 sclPin;
	wire                  sdaPin;

	// target model state
	logic [7:0]           targetRegs [256];
	logic [7:0]           expRegs [256];
	logic                 written [256];
	logic                 targetPull;
	targetState_t         tState;
	targetState_t         afterAck;
	int                   tBitCount;
	logic [7:0]           tShift;
	logic [7:0]           regPtr;

	logic [31:0]          lcgState = 32'd31;
	i2cPkg::i2cResponse_t expQueue [$];
	i2cPkg::i2cResponse_t expRsp;
	string                testName;
	int                   issuedCount = 0;
	int                   doneCount = 0;
	int                   errorCount = 0;
	int                   checkCount = 0;
	int                   testErrors = 0;
	int                   testsRun = 0;
	int                   testsFailed = 0;
	int                   cycleCount = 0;
	int                   lastRspCycle = 0;
	int                   assertFails;

	i2cMaster i_i2cMaster (
		.i2c_clock (i2c_clock),
		.reset     (reset),
		.cmdValid  (cmdValid),
		.cmdReady  (cmdReady),
		.cmdData   (cmdData),
		.rspValid  (rspValid),
		.rspReady  (rspReady),
		.rspData   (rspData),
		.sclPin    (sclPin),
		.sdaPin    (sdaPin)
	);

	// board pull-up plus the target's open-drain pull-down
	pullup (sdaPin);
	assign sdaPin = targetPull ? 1'b0 : 1'bz;

	initial begin
		i2c_clock = 1'b0;
		forever #(clkPeriod / 2) i2c_clock = ~i2c_clock;
	end

	always @(posedge i2c_clock) begin
		cycleCount <= cycleCount + 1;
	end

	initial begin
		for (int i = 0; i < 256; i++) begin
			targetRegs[i] = 8'(i) ^ 8'hA5;
			expRegs[i]    = 8'(i) ^ 8'hA5;
			written[i]    = 1'b0;
		end
		targetPull = 1'b0;
		tState     = tIdle;
		afterAck   = tIdle;
		tBitCount  = 0;
		tShift     = 8'h00;
		regPtr     = 8'h00;
	end

	// start or repeated start, SDA falls with SCL high
	always @(negedge sdaPin) begin
		if (sclPin === 1'b1) begin
			tState     = tAddr;
			tBitCount  = 0;
			targetPull = 1'b0;
		end
	end

	// stop, SDA rises with SCL high
	always @(posedge sdaPin) begin
		if (sclPin === 1'b1) begin
			tState     = tIdle;
			targetPull = 1'b0;
		end
	end

	// target samples on the rising SCL edge
	always @(posedge sclPin) begin
		case (tState)
			tAddr, tReg, tWrData: begin
				tShift    = {tShift[6:0], sdaPin};
				tBitCount = tBitCount + 1;
				if (tBitCount == 8) begin
					tBitCount = 0;
					case (tState)
						tAddr: begin
							afterAck = tShift[0] ? tRdData : tReg;
							// any other address is ignored
							tState = (tShift[7:1] == targetAddr) ? tAckDrive : tIdle;
						end
						tReg: begin
							regPtr   = tShift;
							afterAck = tWrData;
							tState   = tAckDrive;
						end
						default: begin
							targetRegs[regPtr] = tShift;
							afterAck           = tIdle;
							tState             = tAckDrive;
						end
					endcase
				end
			end
			tRdData: begin
				tBitCount = tBitCount + 1;
				if (tBitCount == 8) begin
					tState = tRdRelease;
				end
			end
			// master answers the single byte with NACK
			tRdNack: tState = tIdle;
			default: begin
			end
		endcase
	end

	// target drives SDA only after SCL has fallen
	always @(negedge sclPin) begin
		case (tState)
			tAckDrive: begin
				targetPull = 1'b1;
				tState     = tAckHold;
			end
			tAckHold: begin
				targetPull = 1'b0;
				tState     = afterAck;
				if (afterAck == tRdData) begin
					tShift     = targetRegs[regPtr];
					targetPull = !tShift[7];
				end
			end
			tRdData: begin
				tShift     = tShift << 1;
				targetPull = !tShift[7];
			end
			tRdRelease: begin
				targetPull = 1'b0;
				tState     = tRdNack;
			end
			default: begin
			end
		endcase
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return {16'd0, lcgState[30:15]};
	endfunction

	// expected response from the command and the expected register contents
	function automatic i2cPkg::i2cResponse_t expectResponse(input i2cPkg::i2cCommand_t cmd);
		i2cPkg::i2cResponse_t rsp;
		rsp = '0;
		if (cmd.deviceAddr != targetAddr) begin
			rsp.ackError = 1'b1;
		end else if (cmd.isRead) begin
			rsp.readData = expRegs[cmd.regAddr];
		end
		return rsp;
	endfunction

	function automatic i2cPkg::i2cCommand_t makeCommand(input logic [6:0] addr,
			input logic [7:0] regAddr, input logic [7:0] data, input logic isRead);
		i2cPkg::i2cCommand_t cmd;
		cmd.deviceAddr = addr;
		cmd.regAddr    = regAddr;
		cmd.writeData  = data;
		cmd.isRead     = isRead;
		return cmd;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
		end
	endtask

	// responses are checked on their transfer edge
	always @(posedge i2c_clock) begin
		if (!reset && rspValid && rspReady) begin
			lastRspCycle = cycleCount;
			doneCount    = doneCount + 1;
			if (expQueue.size() == 0) begin
				errorCount++;
				$display("error: a response arrived with no command outstanding");
			end else begin
				expRsp = expQueue.pop_front();
				checkValue("rspData.readData", 32'(rspData.readData), 32'(expRsp.readData));
				checkValue("rspData.ackError", 32'(rspData.ackError), 32'(expRsp.ackError));
			end
		end
	end

	task automatic expectFor(input i2cPkg::i2cCommand_t cmd);
		expQueue.push_back(expectResponse(cmd));
		issuedCount++;
		if (!cmd.isRead && cmd.deviceAddr == targetAddr) begin
			expRegs[cmd.regAddr] = cmd.writeData;
		end
	endtask

	task automatic issueCommand(input i2cPkg::i2cCommand_t cmd);
		@(posedge i2c_clock);
		cmdValid <= 1'b1;
		cmdData  <= cmd;
		expectFor(cmd);
		do begin
			@(posedge i2c_clock);
		end while (!cmdReady);
		cmdValid <= 1'b0;
	endtask

	task automatic runCommand(input i2cPkg::i2cCommand_t cmd);
		issueCommand(cmd);
		while (doneCount < issuedCount) begin
			@(posedge i2c_clock);
		end
	endtask

	task automatic startTest(input string name);
		testName   = name;
		testErrors = errorCount;
	endtask

	task automatic finishTest();
		testsRun++;
		if (errorCount == testErrors) begin
			$display("test %s: ok", testName);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", testName, errorCount - testErrors);
		end
	endtask

	task automatic resetChecks();
		startTest("reset state");
		checkValue("cmdReady", 32'(cmdReady), 32'd1);
		checkValue("rspValid", 32'(rspValid), 32'd0);
		checkValue("sclPin", 32'(sclPin), 32'd1);
		checkValue("sdaPin", 32'(sdaPin), 32'd1);
		finishTest();
	endtask

	task automatic writeReadPairs();
		logic [7:0] regAddr;
		logic [7:0] data;
		startTest("write then read");
		for (int n = 0; n < 20; n++) begin
			regAddr          = 8'(lcgNext());
			data             = 8'(lcgNext());
			written[regAddr] = 1'b1;
			runCommand(makeCommand(targetAddr, regAddr, data, 1'b0));
			runCommand(makeCommand(targetAddr, regAddr, 8'h00, 1'b1));
		end
		finishTest();
	endtask

	task automatic untouchedReads();
		logic [7:0] regAddr;
		startTest("unwritten read");
		for (int n = 0; n < 4; n++) begin
			do begin
				regAddr = 8'(lcgNext());
			end while (written[regAddr]);
			runCommand(makeCommand(targetAddr, regAddr, 8'h00, 1'b1));
		end
		finishTest();
	endtask

	task automatic wrongAddress();
		startTest("wrong address");
		runCommand(makeCommand(7'h2B, 8'h10, 8'h5A, 1'b0));
		runCommand(makeCommand(7'h15, 8'h20, 8'h00, 1'b1));
		// the ignored write must leave every register alone
		for (int i = 0; i < 256; i++) begin
			checkValue($sformatf("targetRegs[%0d]", i), 32'(targetRegs[i]), 32'(expRegs[i]));
		end
		finishTest();
	endtask

	task automatic backPressure();
		i2cPkg::i2cCommand_t  rdCmd;
		i2cPkg::i2cResponse_t held;
		logic [7:0]           regAddr;
		int                   holdCycles;
		int                   acceptCycle;
		startTest("back-pressure");
		regAddr = 8'(lcgNext());
		rdCmd   = makeCommand(targetAddr, regAddr, 8'h00, 1'b1);
		@(posedge i2c_clock);
		rspReady <= 1'b0;
		issueCommand(makeCommand(targetAddr, regAddr, 8'(lcgNext()), 1'b0));
		while (!rspValid) begin
			@(posedge i2c_clock);
		end
		held       = rspData;
		holdCycles = 4 + int'(lcgNext() % 40);
		// next command waits while the response is held back
		cmdValid <= 1'b1;
		cmdData  <= rdCmd;
		expectFor(rdCmd);
		repeat (holdCycles) begin
			@(posedge i2c_clock);
			checkValue("rspValid", 32'(rspValid), 32'd1);
			checkValue("rspData", 32'(rspData), 32'(held));
			checkValue("cmdReady", 32'(cmdReady), 32'd0);
		end
		rspReady <= 1'b1;
		do begin
			@(posedge i2c_clock);
		end while (!cmdReady);
		acceptCycle = cycleCount;
		cmdValid <= 1'b0;
		checkValue("acceptAfterResponse", 32'(acceptCycle > lastRspCycle), 32'd1);
		while (doneCount < issuedCount) begin
			@(posedge i2c_clock);
		end
		finishTest();
	endtask

	initial begin
		cmdValid = 1'b0;
		cmdData  = '0;
		rspReady = 1'b1;
		reset    = 1'b1;
		repeat (16) @(posedge i2c_clock);
		reset <= 1'b0;
		@(posedge i2c_clock);
		resetChecks();
		writeReadPairs();
		untouchedReads();
		wrongAddress();
		backPressure();
		repeat (4) @(posedge i2c_clock);
		if (expQueue.size() != 0) begin
			errorCount++;
			$display("error: %0d responses never arrived", expQueue.size());
		end
		assertFails = i_i2cMaster.i_i2cMaster_asserts.assertFailures;
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			testsRun, testsFailed, checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// bounded by a generous per-command budget
	initial begin
		#(watchdogCycles * clkPeriod);
		$display("error: watchdog expired after %0d cycles, a transaction never finished",
			watchdogCycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/i2cPkg.sv
rtl/sclPhaseGen.sv
rtl/transactionSequencer.sv
rtl/sdaLineDriver.sv
rtl/i2cMaster.sv
verification/i2cMaster_asserts.sv
verification/i2cMaster_tb.sv

// ==== Bender.yml ====
package:
  name: i2c_master

export_include_dirs:
  - rtl

sources:
  - rtl/i2cPkg.sv
  - rtl/sclPhaseGen.sv
  - rtl/transactionSequencer.sv
  - rtl/sdaLineDriver.sv
  - rtl/i2cMaster.sv
  - target: test
    files:
      - verification/i2cMaster_asserts.sv
      - verification/i2cMaster_tb.sv
